/* design/fsab_pkg.sv */
package fsab_pkg;

	localparam int FSAB_ADDR_W = 31;                        // Request address
	localparam int FSAB_DATA_W = 64;                        // Write data
	localparam int FSAB_DID_W = 4;                          // Device id tag

	localparam int FSAB_CLIENTS = 3;                        // dc, ic, pre
	localparam int FSAB_CLIENT_W = $clog2(FSAB_CLIENTS);    // Client index width

	// Fixed client slots, also the round-robin order
	localparam int FSAB_CLIENT_DC = 0;
	localparam int FSAB_CLIENT_IC = 1;
	localparam int FSAB_CLIENT_PRE = 2;

	localparam int FSAB_QUEUE_DEPTH = 4;                    // Entries, and credits after reset
	localparam int FSAB_QUEUE_PTR_W = $clog2(FSAB_QUEUE_DEPTH); // Queue pointer width

	typedef enum logic {
		FSAB_WRITE = 1'b0,                              // Store to memory
		FSAB_READ  = 1'b1                               // Fetch from memory
	} fsab_mode_t;

	// One bus request, 100 bits, mode on top
	typedef struct packed {
		fsab_mode_t               mode;                 // Read or write
		logic [FSAB_DID_W-1:0]    did;                  // Requesting device
		logic [FSAB_ADDR_W-1:0]   addr;                 // Target address
		logic [FSAB_DATA_W-1:0]   data;                 // Write payload
	} fsab_req_t;

	typedef logic [FSAB_CLIENT_W-1:0] fsab_client_t;      // Which queue a request came from

endpackage

/* design/board_pkg.sv */
package board_pkg;

	// Core reset held this many cycles after the cause clears
	localparam int RESET_SEQ_CYCLES = 16;

	// Read LED on-time, short for simulation
	localparam int LED_STRETCH_CYCLES = 50;
	localparam int LED_STRETCH_W = $clog2(LED_STRETCH_CYCLES + 1); // Stretch counter width

	localparam int LED_COUNT = 3;                           // Width of the leds port
	localparam int LED_READY = 0;                           // Core out of reset
	localparam int LED_READ_SEEN = 1;                       // Any read since reset
	localparam int LED_READ_RECENT = 2;                     // Read in the last stretch window

endpackage

/* design/fsab_req_if.sv */
`timescale 1ns/1ns

// One request stream, valid/ready
interface fsab_req_if import fsab_pkg::*; ();

	logic         valid;                                    // Request on offer
	logic         ready;                                    // Taker can accept
	fsab_req_t    req;                                      // Held while valid and not ready
	fsab_client_t client;                                   // Originating client

	modport source (
		output valid, req, client,
		input  ready
	);

	modport sink (
		input  valid, req, client,
		output ready
	);

	// Observes transfers without driving ready
	modport monitor (
		input valid, ready, req, client
	);

endinterface

/* design/reset_sequencer.sv */
`timescale 1ns/1ns

module reset_sequencer import board_pkg::*; (
	input  logic cclk,
	input  logic cclk_rst_cause_b,                          // Async, active low
	output logic cclk_rst_b                                 // Delayed core reset
);

	logic [RESET_SEQ_CYCLES-1:0] seq;                       // Ones walk up from bit 0

	// Cause clears instantly, release is clocked
	always_ff @(posedge cclk or negedge cclk_rst_cause_b) begin
		if (!cclk_rst_cause_b) begin
			seq <= '0;                              // Hold core in reset
		end else begin
			seq <= {seq[RESET_SEQ_CYCLES-2:0], 1'b1}; // Shift in a one per edge
		end
	end

	assign cclk_rst_b = seq[RESET_SEQ_CYCLES-1];            // Top bit set after the full run

	// Release only with the cause high across the whole sequence
	a_release_after_sequence: assert property (
		@(posedge cclk) $rose(cclk_rst_b) |->
			cclk_rst_cause_b && $past(cclk_rst_cause_b, RESET_SEQ_CYCLES - 1)
	) else $error("core reset released while reset cause was low");

endmodule

/* design/client_queue.sv */
`timescale 1ns/1ns

module client_queue import fsab_pkg::*; #(
	parameter fsab_client_t CLIENT_ID = '0                  // Stamped onto every head
) (
	input  logic      cclk,
	input  logic      cclk_rst_b,
	input  logic      in_valid,                             // Client spends a credit
	input  fsab_req_t in_req,
	output logic      credit,                               // One credit back per pulse
	fsab_req_if.source head                                 // Oldest entry toward the arbiter
);

	fsab_req_t                 mem [FSAB_QUEUE_DEPTH];      // Entry storage
	logic [FSAB_QUEUE_PTR_W-1:0] wr_ptr;                    // Next free slot
	logic [FSAB_QUEUE_PTR_W-1:0] rd_ptr;                    // Current head
	logic [FSAB_QUEUE_PTR_W:0]   count;                     // Entries held
	logic                      push;
	logic                      pop;

	assign push = in_valid;                                 // Never refused, credits guard it
	assign pop  = head.valid && head.ready;                 // Head taken by arbiter

	assign head.valid  = (count != '0);
	assign head.req    = mem[rd_ptr];
	assign head.client = CLIENT_ID;

	always_ff @(posedge cclk) begin
		if (push) begin
			mem[wr_ptr] <= in_req;
		end
	end

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			credit <= pop;                          // Pulse the cycle after a transfer
			if (push) begin
				wr_ptr <= (wr_ptr == FSAB_QUEUE_PTR_W'(FSAB_QUEUE_DEPTH - 1)) ?
					'0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == FSAB_QUEUE_PTR_W'(FSAB_QUEUE_DEPTH - 1)) ?
					'0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;        // Idle or both at once
			endcase
		end
	end

	// A client with no credit left has written anyway
	a_no_write_when_full: assert property (
		@(posedge cclk) disable iff (!cclk_rst_b)
		in_valid |-> (count < (FSAB_QUEUE_PTR_W + 1)'(FSAB_QUEUE_DEPTH))
	) else $error("client %0d wrote into a full queue", CLIENT_ID);

endmodule

/* design/request_arbiter.sv */
`timescale 1ns/1ns

module request_arbiter import fsab_pkg::*; (
	input  logic cclk,
	input  logic cclk_rst_b,
	fsab_req_if.sink   heads [FSAB_CLIENTS],                // One per client queue
	fsab_req_if.source out                                  // Toward memory
);

	logic [FSAB_CLIENTS-1:0] head_valid;                    // Flattened head signals
	fsab_req_t               head_req [FSAB_CLIENTS];
	fsab_client_t            head_client [FSAB_CLIENTS];
	logic [FSAB_CLIENTS-1:0] grant;                         // Ready back to each queue

	fsab_client_t last_grant;                               // Round-robin pointer
	fsab_client_t win_idx;                                  // Winner this cycle
	logic         found;                                    // Some head is valid
	logic         load;                                     // Output register takes winner

	logic         out_valid_q;
	fsab_req_t    out_req_q;
	fsab_client_t out_client_q;

	// Interface array elements need constant indices
	for (genvar i = 0; i < FSAB_CLIENTS; i++) begin : g_heads
		assign head_valid[i]  = heads[i].valid;
		assign head_req[i]    = heads[i].req;
		assign head_client[i] = heads[i].client;
		assign heads[i].ready = grant[i];
	end

	// Search starts one past the last grant
	always_comb begin
		int unsigned cand;
		found   = 1'b0;
		win_idx = '0;
		for (int k = 1; k <= FSAB_CLIENTS; k++) begin
			cand = (int'(last_grant) + k) % FSAB_CLIENTS;
			if (!found && head_valid[cand]) begin
				found   = 1'b1;
				win_idx = fsab_client_t'(cand);
			end
		end
	end

	assign load = found && (!out_valid_q || out.ready);     // Empty or draining this cycle

	always_comb begin
		grant = '0;
		if (load) begin
			grant[win_idx] = 1'b1;                  // Only the winner pops
		end
	end

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			out_valid_q <= 1'b0;
			last_grant  <= fsab_client_t'(FSAB_CLIENTS - 1); // dc goes first
		end else begin
			if (load) begin
				out_valid_q <= 1'b1;
				last_grant  <= win_idx;
			end else if (out.ready) begin
				out_valid_q <= 1'b0;            // Drained, nothing to refill
			end
		end
	end

	always_ff @(posedge cclk) begin
		if (load) begin
			out_req_q    <= head_req[win_idx];
			out_client_q <= head_client[win_idx];
		end
	end

	assign out.valid  = out_valid_q;
	assign out.req    = out_req_q;
	assign out.client = out_client_q;

	a_single_grant: assert property (
		@(posedge cclk) disable iff (!cclk_rst_b) $onehot0(grant)
	) else $error("more than one queue popped in one cycle");

	// Memory side stall keeps the request frozen
	a_stall_stable: assert property (
		@(posedge cclk) disable iff (!cclk_rst_b)
		out.valid && !out.ready |=> out.valid && $stable(out.req) && $stable(out.client)
	) else $error("memory request changed while stalled");

endmodule

/* design/activity_monitor.sv */
`timescale 1ns/1ns

module activity_monitor import fsab_pkg::*, board_pkg::*; (
	input  logic cclk,
	input  logic cclk_rst_b,
	fsab_req_if.monitor mem,                                // Tap on the memory port
	output logic read_seen,                                 // Sticky until reset
	output logic read_recent                                // Stretched read pulse
);

	logic                     rd_accept;                    // Read transferred this cycle
	logic [LED_STRETCH_W-1:0] stretch;                      // 0 idle, else cycles lit

	assign rd_accept = mem.valid && mem.ready && (mem.req.mode == FSAB_READ);

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			read_seen <= 1'b0;
			stretch   <= '0;
		end else begin
			if (rd_accept) begin
				read_seen <= 1'b1;
				stretch   <= LED_STRETCH_W'(1); // Restart window
			end else if (stretch == LED_STRETCH_W'(LED_STRETCH_CYCLES)) begin
				stretch <= '0;                  // Window over
			end else if (stretch != '0) begin
				stretch <= stretch + 1'b1;
			end
		end
	end

	assign read_recent = (stretch != '0);

endmodule

/* design/fsab_system.sv */
`timescale 1ns/1ns

module fsab_system import fsab_pkg::*, board_pkg::*; (
	input  logic                   cclk,
	input  logic                   cclk_rst_cause_b,

	// Data cache client
	input  logic                   dc_req_valid,
	input  fsab_mode_t             dc_req_mode,
	input  logic [FSAB_DID_W-1:0]  dc_req_did,
	input  logic [FSAB_ADDR_W-1:0] dc_req_addr,
	input  logic [FSAB_DATA_W-1:0] dc_req_data,
	output logic                   dc_credit,

	// Instruction cache client
	input  logic                   ic_req_valid,
	input  fsab_mode_t             ic_req_mode,
	input  logic [FSAB_DID_W-1:0]  ic_req_did,
	input  logic [FSAB_ADDR_W-1:0] ic_req_addr,
	input  logic [FSAB_DATA_W-1:0] ic_req_data,
	output logic                   ic_credit,

	// Preload client
	input  logic                   pre_req_valid,
	input  fsab_mode_t             pre_req_mode,
	input  logic [FSAB_DID_W-1:0]  pre_req_did,
	input  logic [FSAB_ADDR_W-1:0] pre_req_addr,
	input  logic [FSAB_DATA_W-1:0] pre_req_data,
	output logic                   pre_credit,

	// Memory request port
	output logic                   mem_req_valid,
	output fsab_mode_t             mem_req_mode,
	output logic [FSAB_DID_W-1:0]  mem_req_did,
	output logic [FSAB_ADDR_W-1:0] mem_req_addr,
	output logic [FSAB_DATA_W-1:0] mem_req_data,
	output fsab_client_t           mem_client,
	input  logic                   mem_ready,

	output logic [LED_COUNT-1:0]   leds
);

	logic      cclk_rst_b;                                  // Sequenced core reset
	fsab_req_t dc_req;
	fsab_req_t ic_req;
	fsab_req_t pre_req;

	fsab_req_if head_if [FSAB_CLIENTS] ();                  // Queue heads
	fsab_req_if mem_if ();                                  // Arbiter output

	assign dc_req  = '{mode: dc_req_mode, did: dc_req_did,
		addr: dc_req_addr, data: dc_req_data};
	assign ic_req  = '{mode: ic_req_mode, did: ic_req_did,
		addr: ic_req_addr, data: ic_req_data};
	assign pre_req = '{mode: pre_req_mode, did: pre_req_did,
		addr: pre_req_addr, data: pre_req_data};

	reset_sequencer rst_seq (
		.cclk             (cclk),
		.cclk_rst_cause_b (cclk_rst_cause_b),
		.cclk_rst_b       (cclk_rst_b)
	);

	client_queue #(.CLIENT_ID(fsab_client_t'(FSAB_CLIENT_DC))) dc_queue (
		.cclk       (cclk),
		.cclk_rst_b (cclk_rst_b),
		.in_valid   (dc_req_valid),
		.in_req     (dc_req),
		.credit     (dc_credit),
		.head       (head_if[FSAB_CLIENT_DC])
	);

	client_queue #(.CLIENT_ID(fsab_client_t'(FSAB_CLIENT_IC))) ic_queue (
		.cclk       (cclk),
		.cclk_rst_b (cclk_rst_b),
		.in_valid   (ic_req_valid),
		.in_req     (ic_req),
		.credit     (ic_credit),
		.head       (head_if[FSAB_CLIENT_IC])
	);

	client_queue #(.CLIENT_ID(fsab_client_t'(FSAB_CLIENT_PRE))) pre_queue (
		.cclk       (cclk),
		.cclk_rst_b (cclk_rst_b),
		.in_valid   (pre_req_valid),
		.in_req     (pre_req),
		.credit     (pre_credit),
		.head       (head_if[FSAB_CLIENT_PRE])
	);

	request_arbiter arbiter (
		.cclk       (cclk),
		.cclk_rst_b (cclk_rst_b),
		.heads      (head_if),
		.out        (mem_if)
	);

	activity_monitor activity (
		.cclk        (cclk),
		.cclk_rst_b  (cclk_rst_b),
		.mem         (mem_if),
		.read_seen   (leds[LED_READ_SEEN]),
		.read_recent (leds[LED_READ_RECENT])
	);

	// Memory port maps straight onto the arbiter output
	assign mem_req_valid = mem_if.valid;
	assign mem_req_mode  = mem_if.req.mode;
	assign mem_req_did   = mem_if.req.did;
	assign mem_req_addr  = mem_if.req.addr;
	assign mem_req_data  = mem_if.req.data;
	assign mem_client    = mem_if.client;
	assign mem_if.ready  = mem_ready;

	assign leds[LED_READY] = cclk_rst_b;                    // Lit once core reset lifts

endmodule

/* verification/fsab_system_tb.sv */
`timescale 1ns/1ns

module fsab_system_tb import fsab_pkg::*, board_pkg::*;;

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 8;                          // Cause held low this long
	localparam int WR_CYCLES = 150;                         // Write-only traffic
	localparam int MIX_CYCLES = 300;                        // Mixed traffic with stalls
	localparam int RR_FILL = 12;                            // Queues fill while memory stalls
	localparam int RR_RUN = 60;                             // Full queues, memory always ready
	localparam int DRAIN_BOUND = 40;
	localparam int TEST_CYCLES = RST_CYCLES + RESET_SEQ_CYCLES + WR_CYCLES + MIX_CYCLES +
		RR_FILL + RR_RUN + DRAIN_BOUND + LED_STRETCH_CYCLES + 4;
	localparam int SNAP_W = 1 + FSAB_DID_W + FSAB_ADDR_W + FSAB_DATA_W + FSAB_CLIENT_W;

	logic                   cclk = 1'b0;
	logic                   cclk_rst_cause_b;
	logic                   dc_req_valid;
	fsab_mode_t             dc_req_mode;
	logic [FSAB_DID_W-1:0]  dc_req_did;
	logic [FSAB_ADDR_W-1:0] dc_req_addr;
	logic [FSAB_DATA_W-1:0] dc_req_data;
	logic                   dc_credit;
	logic                   ic_req_valid;
	fsab_mode_t             ic_req_mode;
	logic [FSAB_DID_W-1:0]  ic_req_did;
	logic [FSAB_ADDR_W-1:0] ic_req_addr;
	logic [FSAB_DATA_W-1:0] ic_req_data;
	logic                   ic_credit;
	logic                   pre_req_valid;
	fsab_mode_t             pre_req_mode;
	logic [FSAB_DID_W-1:0]  pre_req_did;
	logic [FSAB_ADDR_W-1:0] pre_req_addr;
	logic [FSAB_DATA_W-1:0] pre_req_data;
	logic                   pre_credit;
	logic                   mem_req_valid;
	fsab_mode_t             mem_req_mode;
	logic [FSAB_DID_W-1:0]  mem_req_did;
	logic [FSAB_ADDR_W-1:0] mem_req_addr;
	logic [FSAB_DATA_W-1:0] mem_req_data;
	fsab_client_t           mem_client;
	logic                   mem_ready;
	logic [LED_COUNT-1:0]   leds;

	logic [31:0]       rng;                                 // Xorshift state
	int                cyc = 0;                             // Rising edges so far
	int                credits [FSAB_CLIENTS];              // Credits each client still holds
	int                credit_cnt [FSAB_CLIENTS];           // Credit pulses seen
	int                xfer_cnt [FSAB_CLIENTS];             // Memory transfers seen
	fsab_req_t         sent_q [FSAB_CLIENTS][$];            // Requests not yet at memory
	int                acc_q [FSAB_CLIENTS][$];             // Edge each one entered its queue
	int                mismatches = 0;
	int                other_errors = 0;
	bit                checks_on = 1'b0;
	bit                rr_check = 1'b0;                     // Strict rotation expected
	int                rr_last = -1;
	int                prev_client = -1;                    // Client of the last transfer
	int                prev_edge = -1;
	int                prev_edge2 = -1;                     // Transfer before that one
	bit                seen_exp = 1'b0;                     // Some read reached memory
	int                last_read_edge = 0;
	bit                stalled = 1'b0;
	logic [SNAP_W-1:0] stall_snap;                          // Outputs frozen by a stall

	fsab_system fsab_system_inst (.*);

	always #(CLK_PERIOD / 2) cclk = ~cclk;

	always @(posedge cclk) cyc <= cyc + 1;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// Reference: oldest request of this client that memory has not taken yet
	function automatic fsab_req_t expected_next(input int client);
		return sent_q[client][0];
	endfunction

	// Requests issued but not yet seen at the memory port
	function automatic int outstanding();
		int n;
		n = 0;
		for (int c = 0; c < FSAB_CLIENTS; c++) begin
			n += sent_q[c].size();
		end
		return n;
	endfunction

	function automatic logic [SNAP_W-1:0] mem_outputs();
		return {mem_req_mode, mem_req_did, mem_req_addr, mem_req_data, mem_client};
	endfunction

	task automatic report_mismatch(input string test, input logic [127:0] exp,
		input logic [127:0] act);
		mismatches++;
		$display("CHECK FAILED %s expected %0h actual %0h at %0t", test, exp, act, $time);
	endtask

	task automatic report_error(input string msg);
		other_errors++;
		$display("ERROR: %s at %0t", msg, $time);
	endtask

	// Credits, memory valid and LEDs quiet, only ready as given
	task automatic check_reset_outputs(input string test, input logic ready_exp);
		logic [6:0] seen;
		seen = {dc_credit, ic_credit, pre_credit, mem_req_valid, leds};
		if (seen !== {6'b0, ready_exp}) begin
			report_mismatch(test, 128'({6'b0, ready_exp}), 128'(seen));
		end
	endtask

	// One clock of client and memory stimulus
	task automatic drive_cycle(input int issue_pct, input bit writes_only, input int stall_pct);
		logic [FSAB_CLIENTS-1:0] v;
		fsab_req_t               r [FSAB_CLIENTS];
		logic [31:0]             w0;
		logic [31:0]             w1;
		logic [31:0]             w2;
		logic [31:0]             w3;
		@(posedge cclk);
		for (int c = 0; c < FSAB_CLIENTS; c++) begin
			v[c] = (credits[c] > 0) && ((next_rand() % 100) < issue_pct);
			w0 = next_rand();
			w1 = next_rand();
			w2 = next_rand();
			w3 = next_rand();
			r[c].mode = writes_only ? FSAB_WRITE : fsab_mode_t'(w0[31]);
			r[c].did  = w0[FSAB_DID_W-1:0];
			r[c].addr = w1[FSAB_ADDR_W-1:0];
			r[c].data = {FSAB_CLIENT_W'(c), w2[29:0], w3}; // Client tag on top
			if (v[c]) begin
				credits[c]--;
				sent_q[c].push_back(r[c]);
				acc_q[c].push_back(cyc + 2);    // Queue takes it next edge
			end
		end
		dc_req_valid  <= v[FSAB_CLIENT_DC];
		dc_req_mode   <= r[FSAB_CLIENT_DC].mode;
		dc_req_did    <= r[FSAB_CLIENT_DC].did;
		dc_req_addr   <= r[FSAB_CLIENT_DC].addr;
		dc_req_data   <= r[FSAB_CLIENT_DC].data;
		ic_req_valid  <= v[FSAB_CLIENT_IC];
		ic_req_mode   <= r[FSAB_CLIENT_IC].mode;
		ic_req_did    <= r[FSAB_CLIENT_IC].did;
		ic_req_addr   <= r[FSAB_CLIENT_IC].addr;
		ic_req_data   <= r[FSAB_CLIENT_IC].data;
		pre_req_valid <= v[FSAB_CLIENT_PRE];
		pre_req_mode  <= r[FSAB_CLIENT_PRE].mode;
		pre_req_did   <= r[FSAB_CLIENT_PRE].did;
		pre_req_addr  <= r[FSAB_CLIENT_PRE].addr;
		pre_req_data  <= r[FSAB_CLIENT_PRE].data;
		mem_ready     <= !((next_rand() % 100) < stall_pct);
	endtask

	// Compare at the falling edge, where all outputs are settled
	always @(negedge cclk) begin
		logic [FSAB_CLIENTS-1:0] credit_in;
		fsab_req_t               got;
		int                      c;
		credit_in = {pre_credit, ic_credit, dc_credit};
		if (!rr_check) rr_last = -1;
		if (checks_on) begin
			for (int k = 0; k < FSAB_CLIENTS; k++) begin
				if (credit_in[k] === 1'b1) begin
					credits[k]++;
					credit_cnt[k]++;
					if (credits[k] > FSAB_QUEUE_DEPTH) begin
						report_error($sformatf("client %0d got back more credits than it spent", k));
					end
				end
			end
			if (stalled && (mem_req_valid !== 1'b1 || mem_outputs() !== stall_snap)) begin
				report_mismatch("back_pressure", 128'({1'b1, stall_snap}),
					128'({mem_req_valid, mem_outputs()}));
			end
			stalled    = (mem_req_valid === 1'b1) && !mem_ready;
			stall_snap = mem_outputs();
			if (leds[LED_READY] !== 1'b1) report_mismatch("led_ready", 1, leds[LED_READY]);
			if (leds[LED_READ_SEEN] !== seen_exp) begin
				report_mismatch("led_read_seen", seen_exp, leds[LED_READ_SEEN]);
			end
			if (seen_exp && cyc == last_read_edge && leds[LED_READ_RECENT] !== 1'b1) begin
				report_mismatch("led_read_recent_on", 1, leds[LED_READ_RECENT]);
			end
			if ((!seen_exp || cyc - last_read_edge >= LED_STRETCH_CYCLES + 2) &&
				leds[LED_READ_RECENT] !== 1'b0) begin
				report_mismatch("led_read_recent_off", 0, leds[LED_READ_RECENT]);
			end
			if (mem_req_valid === 1'b1 && mem_ready) begin // Transfer on the next edge
				c = int'(mem_req_data[FSAB_DATA_W-1 -: FSAB_CLIENT_W]);
				if (c >= FSAB_CLIENTS || sent_q[c].size() == 0) begin
					report_error($sformatf("memory took a request nobody issued, tag %0d", c));
				end else begin
					got = '{mode: mem_req_mode, did: mem_req_did, addr: mem_req_addr,
						data: mem_req_data};
					if (mem_client !== fsab_client_t'(c)) report_mismatch("mem_client", c, mem_client);
					if (got !== expected_next(c)) begin
						report_mismatch("ordering", 128'(expected_next(c)), 128'(got));
					end
					// Same client twice while another waited from before
					if (c == prev_client && prev_edge2 >= 0) begin
						for (int d = 0; d < FSAB_CLIENTS; d++) begin
							if (d != c && acc_q[d].size() != 0 && acc_q[d][0] < prev_edge2) begin
								report_error($sformatf("client %0d served twice while %0d waited", c, d));
							end
						end
					end
					if (rr_check && rr_last >= 0 && c != (rr_last + 1) % FSAB_CLIENTS) begin
						report_mismatch("round_robin", (rr_last + 1) % FSAB_CLIENTS, c);
					end
					rr_last     = c;
					prev_edge2  = prev_edge;
					prev_edge   = cyc + 1;
					prev_client = c;
					void'(sent_q[c].pop_front());
					void'(acc_q[c].pop_front());
					xfer_cnt[c]++;
					if (mem_req_mode == FSAB_READ) begin
						seen_exp       = 1'b1;
						last_read_edge = cyc + 1;
					end
				end
			end
		end
	end

	initial begin
		int total;
		rng              = 32'd49;
		cclk_rst_cause_b = 1'b0;
		{dc_req_valid, ic_req_valid, pre_req_valid} = '0;
		dc_req_mode  = FSAB_WRITE;
		ic_req_mode  = FSAB_WRITE;
		pre_req_mode = FSAB_WRITE;
		{dc_req_did, ic_req_did, pre_req_did} = '0;
		{dc_req_addr, ic_req_addr, pre_req_addr} = '0;
		{dc_req_data, ic_req_data, pre_req_data} = '0;
		mem_ready = 1'b0;
		for (int c = 0; c < FSAB_CLIENTS; c++) begin
			credits[c]    = FSAB_QUEUE_DEPTH;
			credit_cnt[c] = 0;
			xfer_cnt[c]   = 0;
		end
		for (int i = 0; i < RST_CYCLES; i++) begin
			@(posedge cclk);
			if (i == RST_CYCLES - 1) cclk_rst_cause_b <= 1'b1;
			@(negedge cclk);
			check_reset_outputs("reset_hold", 1'b0);
		end
		for (int i = 1; i <= RESET_SEQ_CYCLES; i++) begin // Edges after the cause lifts
			@(negedge cclk);
			check_reset_outputs("reset_release", i == RESET_SEQ_CYCLES);
		end
		checks_on = 1'b1;
		repeat (WR_CYCLES) drive_cycle(50, 1'b1, 30);
		repeat (MIX_CYCLES) drive_cycle(50, 1'b0, 30);
		repeat (RR_FILL) drive_cycle(100, 1'b0, 100);
		rr_check = 1'b1;
		repeat (RR_RUN) drive_cycle(100, 1'b0, 0);
		rr_check = 1'b0;
		while (outstanding() != 0) drive_cycle(0, 1'b0, 0);
		repeat (LED_STRETCH_CYCLES + 4) drive_cycle(0, 1'b0, 0); // Read LED times out
		total = 0;
		for (int c = 0; c < FSAB_CLIENTS; c++) begin
			if (credit_cnt[c] != xfer_cnt[c]) begin
				report_mismatch("credit_count", 128'(xfer_cnt[c]), 128'(credit_cnt[c]));
			end
			total += xfer_cnt[c];
		end
		if (!seen_exp) report_error("no read request ever reached the memory port");
		$display("Done: %0d transfers, %0d value mismatches, %0d other errors",
			total, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Bounds the run at four times its planned length
	initial begin
		#(TEST_CYCLES * 4 * CLK_PERIOD);
		$display("Watchdog: run did not finish within %0d cycles, stopping", TEST_CYCLES * 4);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* fsab_system.f */
design/fsab_pkg.sv
design/board_pkg.sv
design/fsab_req_if.sv
design/reset_sequencer.sv
design/client_queue.sv
design/request_arbiter.sv
design/activity_monitor.sv
design/fsab_system.sv
verification/fsab_system_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := fsab_system_tb
FILELIST  := fsab_system.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := SIMULATION FAILED
PASS_MSG  := SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
